// File: Makefile
VERILATOR  := verilator
TOP        := lu_tb
FILELIST   := compile.f
OBJ_DIR    := obj_dir
COMMON     := --timing -Wno-fatal --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary --assert --Mdir $(OBJ_DIR) $(COMMON)
PASS_MSG   := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS)

sim:
	$(VERILATOR) $(SIM_FLAGS)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
+incdir+include
rtl/lu_pkg.sv
rtl/cplx_mul.sv
rtl/cplx_recip.sv
rtl/row_mem.sv
rtl/lu_ctrl.sv
rtl/lu_top.sv
tests/lu_checker.sv
tests/lu_tb.sv

// File: include/lu_cfg.svh
`ifndef LU_CFG_SVH
`define LU_CFG_SVH

// matrix is LU_SIZE x LU_SIZE
`define LU_SIZE 4

// bits per real or imaginary part
`define LU_WIDTH 16

// fraction bits of each part
`define LU_FRAC 12

// row index width, clog2 of LU_SIZE
`define LU_ADDR_W 2

`endif

// File: rtl/cplx_mul.sv
`timescale 1ns/1ps
`include "lu_cfg.svh"

module cplx_mul import lu_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  cplx_t a_i,
  input  cplx_t b_i,
  input  logic  in_valid_i,
  output logic  in_ready_o,
  output cplx_t p_o,
  output logic  out_valid_o,
  input  logic  out_ready_i
);

  localparam int W = `LU_WIDTH;
  localparam int F = `LU_FRAC;

  part_t a_re, a_im, b_re, b_im;
  logic signed [2*W-1:0] pp_rr, pp_ii, pp_ri, pp_ir; // stage 1
  logic signed [2*W:0]   sum_re, sum_im;
  logic s1_valid;
  logic advance;

  assign a_re = a_i[W-1:0];
  assign a_im = a_i[2*W-1:W];
  assign b_re = b_i[W-1:0];
  assign b_im = b_i[2*W-1:W];

  // stage 2 free or draining this cycle
  assign advance    = !out_valid_o || out_ready_i;
  assign in_ready_o = advance;

  assign sum_re = pp_rr - pp_ii;
  assign sum_im = pp_ri + pp_ir;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      s1_valid    <= 1'b0;
      out_valid_o <= 1'b0;
    end else if (advance) begin
      s1_valid    <= in_valid_i;
      out_valid_o <= s1_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance && in_valid_i) begin
      pp_rr <= a_re * b_re;
      pp_ii <= a_im * b_im;
      pp_ri <= a_re * b_im;
      pp_ir <= a_im * b_re;
    end
    if (advance && s1_valid) begin
      p_o <= {sum_im[F +: W], sum_re[F +: W]}; // >>> F, keep low part
    end
  end

endmodule

// File: rtl/cplx_recip.sv
`timescale 1ns/1ps
`include "lu_cfg.svh"

module cplx_recip import lu_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  cplx_t z_i,
  input  logic  in_valid_i,
  output cplx_t q_o,
  output logic  out_valid_o,
  output logic  busy_o
);

  localparam int W = `LU_WIDTH;
  localparam int F = `LU_FRAC;
  localparam int Q_W = W + F;                       // quotient bits, one per cycle
  localparam int DIV_EXP = Q_W + 4 * F - 2 * W + 1; // reciprocal is 2**DIV_EXP / |z|^2
  localparam int SHIFT = DIV_EXP - 2 * F;
  localparam int M_W = 2 * W + 1;
  localparam logic [M_W-1:0] REM_INIT = 1 << (DIV_EXP - Q_W);

  typedef enum logic [1:0] {R_IDLE, R_MAG, R_DIV, R_SCALE} recip_phase_t;

  recip_phase_t phase;
  logic [$clog2(Q_W)-1:0] cnt;
  part_t z_re, z_im;
  logic signed [2*W-1:0] sq_re, sq_im;
  logic [M_W-1:0] mag, rem;
  logic [M_W:0]   rem_sh, diff;
  logic [Q_W-1:0] quo;
  logic signed [Q_W+W:0] prod_re, prod_im;

  assign busy_o = (phase != R_IDLE);

  assign sq_re = z_re * z_re;
  assign sq_im = z_im * z_im;

  // restoring step, low dividend bits are all zero
  assign rem_sh = {rem, 1'b0};
  assign diff   = rem_sh - {1'b0, mag};

  // conjugate times reciprocal, floor via arithmetic slice
  assign prod_re = z_re * $signed({1'b0, quo});
  assign prod_im = -(z_im * $signed({1'b0, quo}));

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      phase       <= R_IDLE;
      cnt         <= '0;
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= 1'b0;
      case (phase)
        R_IDLE:  if (in_valid_i) phase <= R_MAG;
        R_MAG: begin
          cnt   <= '0;
          phase <= R_DIV;
        end
        R_DIV: begin
          cnt <= cnt + 1'b1;
          if (cnt == $clog2(Q_W)'(Q_W - 1)) phase <= R_SCALE;
        end
        default: begin
          out_valid_o <= 1'b1;
          phase       <= R_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    case (phase)
      R_IDLE: if (in_valid_i) {z_im, z_re} <= z_i;
      R_MAG: begin
        mag <= {1'b0, sq_re} + {1'b0, sq_im};
        rem <= REM_INIT;
      end
      R_DIV: begin
        if (!diff[M_W]) rem <= diff[M_W-1:0];
        else rem <= rem_sh[M_W-1:0];
        quo <= {quo[Q_W-2:0], !diff[M_W]};
      end
      default: q_o <= {prod_im[SHIFT +: W], prod_re[SHIFT +: W]};
    endcase
  end

endmodule

// File: rtl/lu_ctrl.sv
`timescale 1ns/1ps
`include "lu_cfg.svh"

module lu_ctrl import lu_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  start_i,
  output logic  in_ready_o,
  output logic  busy_o,
  output logic  rd_valid_o,
  output addr_t rd_addr_o,
  input  row_t  rd_row_i,
  input  addr_t rd_addr_i,
  input  logic  rd_valid_i,
  output logic  wr_en_o,
  output addr_t wr_addr_o,
  output row_t  wr_row_o,
  output row_t  l_col_o,
  output row_t  u_row_o,
  output addr_t result_addr_o,
  output logic  result_valid_o,
  input  logic  result_ready_i
);

  localparam int W = `LU_WIDTH;
  localparam int CW = 2 * W;
  localparam addr_t LAST = addr_t'(`LU_SIZE - 1);
  localparam cplx_t ONE = cplx_t'(1 << `LU_FRAC); // 1.0, imag zero

  lu_state_t state;
  addr_t k;      // pivot index
  addr_t l_ptr;  // next L entry
  addr_t wb_ptr; // next row to write back
  row_t  row_buf [`LU_SIZE];

  logic  piv_resp, elim_resp;
  logic  recip_start, recip_valid, recip_busy;
  cplx_t recip_q;
  logic  mul_in_ready, mul_out_valid, mul_out_ready, mul_fire;
  cplx_t mul_p;
  logic [`LU_SIZE-1:0] vec_in_ready, vec_out_valid;
  cplx_t vec_p [`LU_SIZE];

  assign in_ready_o     = (state == IDLE);
  assign busy_o         = (state != IDLE);
  assign result_valid_o = (state == EMIT);
  assign result_addr_o  = k;

  assign piv_resp    = (state == PIVOT) && rd_valid_i && (rd_addr_i == k);
  assign elim_resp   = (state == ELIM) && rd_valid_i;
  assign recip_start = piv_resp && (k != LAST) && !recip_busy; // last pivot needs no divide

  assign mul_out_ready = &vec_in_ready;
  assign mul_fire      = mul_out_valid && mul_out_ready;

  assign wr_en_o   = (state == ELIM) && (&vec_out_valid);
  assign wr_addr_o = wb_ptr;

  cplx_recip u_recip (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .z_i         (rd_row_i[k*CW +: CW]),
    .in_valid_i  (recip_start),
    .q_o         (recip_q),
    .out_valid_o (recip_valid),
    .busy_o      (recip_busy)
  );

  // multiplier l = a[r][k] / a[k][k]
  cplx_mul u_mul (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .a_i         (rd_row_i[k*CW +: CW]),
    .b_i         (recip_q),
    .in_valid_i  (elim_resp),
    .in_ready_o  (mul_in_ready),
    .p_o         (mul_p),
    .out_valid_o (mul_out_valid),
    .out_ready_i (mul_out_ready)
  );

  for (genvar j = 0; j < `LU_SIZE; j++) begin : g_row
    cplx_mul u_vec_mul (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .a_i         (mul_p),
      .b_i         (u_row_o[j*CW +: CW]),
      .in_valid_i  (mul_fire),
      .in_ready_o  (vec_in_ready[j]),
      .p_o         (vec_p[j]),
      .out_valid_o (vec_out_valid[j]),
      .out_ready_i (1'b1)
    );

    // row minus l times U row, per part
    assign wr_row_o[j*CW +: W]     = row_buf[wb_ptr][j*CW +: W] - vec_p[j][W-1:0];
    assign wr_row_o[j*CW + W +: W] = row_buf[wb_ptr][j*CW + W +: W] - vec_p[j][CW-1:W];
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state      <= IDLE;
      k          <= '0;
      l_ptr      <= '0;
      wb_ptr     <= '0;
      rd_valid_o <= 1'b0;
      rd_addr_o  <= '0;
    end else begin
      rd_valid_o <= 1'b0;
      case (state)
        IDLE: begin
          if (start_i) begin
            state      <= PIVOT;
            k          <= '0;
            rd_valid_o <= 1'b1; // fetch row 0
            rd_addr_o  <= '0;
          end
        end
        PIVOT: begin
          if (piv_resp && k == LAST) begin
            state <= EMIT;
          end else if (recip_valid) begin
            state      <= ELIM;
            rd_valid_o <= 1'b1;
            rd_addr_o  <= k + 1'b1;
            l_ptr      <= k + 1'b1;
            wb_ptr     <= k + 1'b1;
          end
        end
        ELIM: begin
          // rows below pivot, back to back
          if (rd_valid_o && rd_addr_o != LAST) begin
            rd_valid_o <= 1'b1;
            rd_addr_o  <= rd_addr_o + 1'b1;
          end
          if (mul_fire) l_ptr <= l_ptr + 1'b1;
          if (wr_en_o) begin
            wb_ptr <= wb_ptr + 1'b1;
            if (wb_ptr == LAST) state <= EMIT;
          end
        end
        default: begin
          if (result_ready_i) begin
            if (k == LAST) begin
              state <= IDLE;
            end else begin
              state      <= PIVOT;
              k          <= k + 1'b1;
              rd_valid_o <= 1'b1;
              rd_addr_o  <= k + 1'b1;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (piv_resp) begin
      for (int j = 0; j < `LU_SIZE; j++) begin
        if (j < int'(k)) u_row_o[j*CW +: CW] <= '0;
        else u_row_o[j*CW +: CW] <= rd_row_i[j*CW +: CW];
      end
      l_col_o             <= '0;
      l_col_o[k*CW +: CW] <= ONE;
    end
    if (mul_fire) l_col_o[l_ptr*CW +: CW] <= mul_p;
    if (elim_resp && mul_in_ready) row_buf[rd_addr_i] <= rd_row_i; // kept for subtraction
  end

endmodule

// File: rtl/lu_pkg.sv
`include "lu_cfg.svh"

package lu_pkg;

  // one signed real or imaginary part
  typedef logic signed [`LU_WIDTH-1:0] part_t;

  // complex element {imag, real}
  typedef logic [2*`LU_WIDTH-1:0] cplx_t;

  // a full row, element 0 in the low bits
  typedef logic [`LU_SIZE*2*`LU_WIDTH-1:0] row_t;

  typedef logic [`LU_ADDR_W-1:0] addr_t;

  typedef enum logic [1:0] {
    IDLE,
    PIVOT, // read pivot row, run reciprocal
    ELIM,  // eliminate rows below pivot
    EMIT   // present L column and U row
  } lu_state_t;

endpackage

// File: rtl/lu_top.sv
`timescale 1ns/1ps

module lu_top import lu_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  load_we_i,
  input  addr_t load_addr_i,
  input  row_t  load_row_i,
  input  logic  start_i,
  output logic  in_ready_o,
  output logic  busy_o,
  output row_t  l_col_o,
  output row_t  u_row_o,
  output addr_t result_addr_o,
  output logic  result_valid_o,
  input  logic  result_ready_i
);

  // controller to row store
  logic  rd_req_valid;
  addr_t rd_req_addr;
  // row store responses
  row_t  rd_row;
  addr_t rd_resp_addr;
  logic  rd_resp_valid;
  // write-back
  logic  wr_en;
  addr_t wr_addr;
  row_t  wr_row;

  row_mem u_row_mem (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .load_we_i   (load_we_i),
    .load_addr_i (load_addr_i),
    .load_row_i  (load_row_i),
    .rd_valid_i  (rd_req_valid),
    .rd_addr_i   (rd_req_addr),
    .rd_row_o    (rd_row),
    .rd_addr_o   (rd_resp_addr),
    .rd_valid_o  (rd_resp_valid),
    .wr_en_i     (wr_en),
    .wr_addr_i   (wr_addr),
    .wr_row_i    (wr_row)
  );

  lu_ctrl u_lu_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (start_i),
    .in_ready_o     (in_ready_o),
    .busy_o         (busy_o),
    .rd_valid_o     (rd_req_valid),
    .rd_addr_o      (rd_req_addr),
    .rd_row_i       (rd_row),
    .rd_addr_i      (rd_resp_addr),
    .rd_valid_i     (rd_resp_valid),
    .wr_en_o        (wr_en),
    .wr_addr_o      (wr_addr),
    .wr_row_o       (wr_row),
    .l_col_o        (l_col_o),
    .u_row_o        (u_row_o),
    .result_addr_o  (result_addr_o),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i)
  );

endmodule

// File: rtl/row_mem.sv
`timescale 1ns/1ps
`include "lu_cfg.svh"

module row_mem import lu_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,

  // matrix load from outside
  input  logic  load_we_i,
  input  addr_t load_addr_i,
  input  row_t  load_row_i,

  // controller read, answered one cycle later
  input  logic  rd_valid_i,
  input  addr_t rd_addr_i,
  output row_t  rd_row_o,
  output addr_t rd_addr_o,
  output logic  rd_valid_o,

  // elimination write-back, always accepted
  input  logic  wr_en_i,
  input  addr_t wr_addr_i,
  input  row_t  wr_row_i
);

  row_t mem [`LU_SIZE];

  always_ff @(posedge clk_i) begin
    if (load_we_i) begin
      mem[load_addr_i] <= load_row_i;
    end else if (wr_en_i) begin
      mem[wr_addr_i] <= wr_row_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_valid_i) begin
      rd_row_o  <= mem[rd_addr_i]; // old row on same-cycle write
      rd_addr_o <= rd_addr_i;      // echo for response matching
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= rd_valid_i;
    end
  end

endmodule

// File: tests/lu_checker.sv
`timescale 1ns/1ps

module lu_checker import lu_pkg::*; (
  input logic  clk_i,
  input logic  rst_ni,
  input logic  load_we_i,
  input logic  wr_en_i,
  input logic  rd_valid_i,
  input logic  busy_i,  // low exactly in IDLE
  input logic  result_valid_i,
  input logic  result_ready_i,
  input addr_t result_addr_i
);

  a_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid_i && !result_ready_i |=> result_valid_i && $stable(result_addr_i))
    else $error("result_valid_o dropped or result_addr_o moved before ready");

  // row store has a single write port
  a_one_writer: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(load_we_i && wr_en_i))
    else $error("load and write-back strobes active in the same cycle");

  a_idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !busy_i |-> !rd_valid_i && !wr_en_i)
    else $error("row read or write-back issued while the controller is idle");

endmodule

// File: tests/lu_input.txt
# per test: name, 4 matrix rows, 4 expected L columns, 4 expected U rows
# each line: 4 elements as hex {imag, real}, element 0 first, 12 fraction bits
real_pow2
00004000 00001000 00000800 00001000
00002000 00004800 00001400 00001000
00001000 00001400 00004600 00001600
0000F000 00000C00 0000F200 00003A00

00001000 00000800 00000400 0000FC00
00000000 00001000 00000400 00000400
00000000 00000000 00001000 0000FC00
00000000 00000000 00000000 00001000

00004000 00001000 00000800 00001000
00000000 00004000 00001000 00000800
00000000 00000000 00004000 00001000
00000000 00000000 00000000 00004000

complex_mix
00004000 10001000 08000000 0000F000
10000000 24001C00 00000E00 F4000800
0000F000 0C00EC00 06004000 14000800
00001000 FC00FC00 1200FC00 02003600

00001000 04000000 0000FC00 00000400
00000000 00001000 08000000 0000FC00
00000000 00000000 00001000 04000000
00000000 00000000 00000000 00001000

00004000 10001000 08000000 0000F000
00000000 20002000 00001000 F8000800
00000000 00000000 00004000 10000000
00000000 00000000 00000000 00004000

// File: tests/lu_tb.sv
`timescale 1ns/1ps
`include "lu_cfg.svh"

module lu_tb import lu_pkg::*; ();

  localparam int N = `LU_SIZE;
  localparam int W = `LU_WIDTH;
  localparam int CW = 2 * W;
  localparam int MAX_TESTS = 4;
  localparam int TOL = 2;               // LSB per part
  localparam int CYCLES_PER_TEST = 2000;
  localparam cplx_t ONE = cplx_t'(1 << `LU_FRAC);

  logic  clk;
  logic  rst_n;
  logic  load_we;
  addr_t load_addr;
  row_t  load_row;
  logic  start;
  logic  in_ready;
  logic  busy;
  row_t  l_col;
  row_t  u_row;
  addr_t res_addr;
  logic  res_valid;
  logic  res_ready;

  row_t a_rows [MAX_TESTS][N];
  row_t l_cols [MAX_TESTS][N]; // expected L, one column per result
  row_t u_rows [MAX_TESTS][N];
  logic [8*24-1:0] names [MAX_TESTS];
  int n_tests;
  int value_errors;
  int proto_errors;
  int cycles;
  int cycle_limit;
  logic [31:0] rng;

  lu_top DUT (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .load_we_i      (load_we),
    .load_addr_i    (load_addr),
    .load_row_i     (load_row),
    .start_i        (start),
    .in_ready_o     (in_ready),
    .busy_o         (busy),
    .l_col_o        (l_col),
    .u_row_o        (u_row),
    .result_addr_o  (res_addr),
    .result_valid_o (res_valid),
    .result_ready_i (res_ready)
  );

  bind lu_top lu_checker u_checker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .load_we_i      (load_we_i),
    .wr_en_i        (wr_en),
    .rd_valid_i     (rd_req_valid),
    .busy_i         (busy_o),
    .result_valid_i (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_addr_i  (result_addr_o)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("errors: %0d value, %0d protocol", value_errors, proto_errors);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic bit within_tol(input cplx_t got, input cplx_t expv);
    part_t g_re, g_im, e_re, e_im;
    int d_re, d_im;
    g_re = got[W-1:0];
    g_im = got[CW-1:W];
    e_re = expv[W-1:0];
    e_im = expv[CW-1:W];
    d_re = int'(g_re) - int'(e_re);
    d_im = int'(g_im) - int'(e_im);
    if (d_re < 0) d_re = -d_re;
    if (d_im < 0) d_im = -d_im;
    return (d_re <= TOL) && (d_im <= TOL);
  endfunction

  task automatic read_row(input int fd, output row_t r);
    int code;
    cplx_t e;
    for (int j = 0; j < N; j++) begin
      code = $fscanf(fd, "%h", e);
      if (code != 1) begin
        proto_errors++;
        $display("could not read a matrix element from tests/lu_input.txt");
      end
      r[j*CW +: CW] = e;
    end
  endtask

  task automatic read_tests();
    int fd;
    int code;
    logic [8*24-1:0] tok;
    logic [8*160-1:0] skip;
    n_tests = 0;
    fd = $fopen("tests/lu_input.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/lu_input.txt");
      proto_errors++;
    end else begin
      while (!$feof(fd) && n_tests < MAX_TESTS) begin
        code = $fscanf(fd, "%s", tok);
        if (code != 1) break;
        if (tok == "#") begin
          code = $fgets(skip, fd); // comment line
        end else begin
          names[n_tests] = tok;
          for (int r = 0; r < N; r++) read_row(fd, a_rows[n_tests][r]);
          for (int r = 0; r < N; r++) read_row(fd, l_cols[n_tests][r]);
          for (int r = 0; r < N; r++) read_row(fd, u_rows[n_tests][r]);
          n_tests++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_elem(input int t, input string what, input bit exact,
                            input cplx_t expv, input cplx_t got);
    bit ok;
    if (exact) ok = (got === expv);
    else ok = within_tol(got, expv);
    if (!ok) begin
      value_errors++;
      $display("FAIL %0s %0s expected %h actual %h", names[t], what, expv, got);
    end
  endtask

  // one transfer, pivot k = idx
  task automatic check_result(input int t, input int idx);
    cplx_t l_e, u_e;
    if (res_addr !== addr_t'(idx)) begin
      value_errors++;
      $display("FAIL %0s result_addr expected %0d actual %0d", names[t], idx, res_addr);
    end
    for (int i = 0; i < N; i++) begin
      l_e = l_col[i*CW +: CW];
      u_e = u_row[i*CW +: CW];
      if (i == idx) check_elem(t, $sformatf("L[%0d][%0d]", i, idx), 1'b1, ONE, l_e);
      else if (i < idx) check_elem(t, $sformatf("L[%0d][%0d]", i, idx), 1'b1, '0, l_e);
      else check_elem(t, $sformatf("L[%0d][%0d]", i, idx), 1'b0,
                      l_cols[t][idx][i*CW +: CW], l_e);
      if (i < idx) check_elem(t, $sformatf("U[%0d][%0d]", idx, i), 1'b1, '0, u_e);
      else if (idx == 0) check_elem(t, $sformatf("U[0][%0d]", i), 1'b1,
                                    a_rows[t][0][i*CW +: CW], u_e);
      else check_elem(t, $sformatf("U[%0d][%0d]", idx, i), 1'b0,
                      u_rows[t][idx][i*CW +: CW], u_e);
    end
  endtask

  task automatic load_matrix(input int t);
    for (int r = 0; r < N; r++) begin
      load_we   = 1'b1;
      load_addr = addr_t'(r);
      load_row  = a_rows[t][r];
      @(negedge clk);
    end
    load_we = 1'b0;
  endtask

  task automatic run_test(input int t);
    int got;
    bit stalled;
    row_t held_l, held_u;
    addr_t held_addr;
    load_matrix(t);
    while (!in_ready) @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    if (!busy) begin
      proto_errors++;
      $display("%0s: busy_o did not rise after start", names[t]);
    end
    got = 0;
    stalled = 1'b0;
    while (got < N) begin
      if (stalled) begin
        if (!res_valid || l_col !== held_l || u_row !== held_u || res_addr !== held_addr) begin
          proto_errors++;
          $display("%0s: result changed while waiting for ready", names[t]);
        end
      end
      stalled = 1'b0;
      rng = xorshift32(rng);
      res_ready = (rng[1:0] != 2'b00); // low about one cycle in four
      if (res_valid) begin
        if (res_ready) begin
          check_result(t, got); // transfer at the next rising edge
          got++;
        end else begin
          stalled   = 1'b1;
          held_l    = l_col;
          held_u    = u_row;
          held_addr = res_addr;
        end
      end
      @(negedge clk);
    end
    res_ready = 1'b0;
    if (busy || !in_ready || res_valid) begin
      proto_errors++;
      $display("%0s: controller not idle after the last result", names[t]);
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    load_we      = 1'b0;
    load_addr    = '0;
    load_row     = '0;
    start        = 1'b0;
    res_ready    = 1'b0;
    value_errors = 0;
    proto_errors = 0;
    cycles       = 0;
    rng          = 32'd70;
    cycle_limit  = CYCLES_PER_TEST;
    read_tests();
    if (n_tests == 0) begin
      $display("no test found in tests/lu_input.txt");
      proto_errors++;
    end else begin
      cycle_limit = n_tests * CYCLES_PER_TEST;
    end
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    for (int t = 0; t < n_tests; t++) run_test(t);
    $display("errors: %0d value, %0d protocol", value_errors, proto_errors);
    if (value_errors + proto_errors != 0) begin
      $display("Done: errors found");
    end else begin
      $display("Done: no errors");
    end
    $finish;
  end

endmodule
